// ==== spi_sub_defines.svh ====
// sizing macros for the shared spi master subsystem
// transfer width, chip selects, client count, divider width and default
`ifndef SPI_SUB_DEFINES_SVH
`define SPI_SUB_DEFINES_SVH

// one full-duplex transfer
`define SPI_DATA_W		8		// bits per transfer

// serial bus side
`define SPI_NUM_CS		2		// slave select lines
`define SPI_DIV_W		16		// half-period divider width

// client side
`define SPI_NUM_CLIENTS	2		// peer clients behind the arbiter

// half period = div + 1 sys_clk cycles
`define SPI_DIV_DEFAULT	16'd3	// typical divider value

`endif

// ==== spi_bus_pkg.sv ====
// serial bus types for the spi master
// transfer byte, chip-select index, engine states
`include "spi_sub_defines.svh"
`default_nettype none

package spi_bus_pkg;

	// one shifted byte
	typedef logic [`SPI_DATA_W-1:0] spi_data_t;		// msb goes out first

	// which slave is addressed
	typedef logic [$clog2(`SPI_NUM_CS)-1:0] spi_cs_idx_t;	// decoded to cs_n

	// engine FSM
	typedef enum logic [2:0] {
		ST_IDLE			= 3'd0,		// waiting for start
		ST_SCLK_WAIT	= 3'd1,		// counting half period
		ST_SCLK_EDGE	= 3'd2,		// sclk toggles here
		ST_LAST_HALF	= 3'd3,		// hold after last edge
		ST_RSP_HOLD		= 3'd4		// done_valid until accepted
	} spi_state_t;

endpackage

`default_nettype wire

// ==== spi_client_pkg.sv ====
// client side types for the spi master
// request payload, response payload, client id
`include "spi_sub_defines.svh"
`default_nettype none

package spi_client_pkg;

	import spi_bus_pkg::*;

	// engine owner
	typedef logic [$clog2(`SPI_NUM_CLIENTS)-1:0] client_id_t;	// 0 or 1

	// request payload, 9 bits
	typedef struct packed {
		spi_data_t		data;	// byte to send
		spi_cs_idx_t	cs;		// target slave
	} spi_req_t;

	// response is just the received byte
	typedef spi_data_t spi_rsp_t;	// sampled from miso

endpackage

`default_nettype wire

// ==== spi_req_buffer.sv ====
// one-entry valid/ready holding register
// generic payload type, refills in the same cycle it drains
`timescale 1ns/100ps
`default_nettype none

module spi_req_buffer #(
	parameter type payload_t = logic [7:0]		// carried item
) (
	input  logic		sys_clk,				// system clock
	input  logic		sys_rst_n,				// sync reset, low active

	input  logic		in_valid,				// upstream offers item
	output logic		in_ready,				// slot free or draining
	input  payload_t	in_data,				// upstream item

	output logic		out_valid,				// slot holds an item
	input  logic		out_ready,				// downstream pops
	output payload_t	out_data				// held item
);

	logic		full;		// slot occupied
	payload_t	data_q;		// stored payload
	logic		push;		// accepted this cycle

	assign push			= in_valid && in_ready;
	assign in_ready		= ~full | out_ready;	// take new item while draining
	assign out_valid	= full;
	assign out_data		= data_q;

	// occupancy flag
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			full	<= 1'b0;
		else
			full	<= push | (full & ~out_ready);	// stays if not popped
	end

	// payload, no reset needed
	always_ff @(posedge sys_clk) begin
		if (push)
			data_q	<= in_data;
	end

endmodule

`default_nettype wire

// ==== spi_rr_arbiter.sv ====
// round-robin grant of the spi engine to two clients
// remembers the owner and steers the response back to it
`timescale 1ns/100ps
`include "spi_sub_defines.svh"
`default_nettype none

module spi_rr_arbiter
	import spi_client_pkg::*;
(
	input  logic							sys_clk,		// system clock
	input  logic							sys_rst_n,		// sync reset, low active

	input  logic [`SPI_NUM_CLIENTS-1:0]		req_valid,		// buffer holds a request
	output logic [`SPI_NUM_CLIENTS-1:0]		req_pop,		// drain granted buffer
	input  spi_req_t						req_data0,		// client 0 payload
	input  spi_req_t						req_data1,		// client 1 payload

	output logic							start_valid,	// kick the engine
	input  logic							start_ready,	// engine idle
	output spi_req_t						start_req,		// granted payload

	input  logic							done_valid,		// engine has a byte
	output logic							done_ready,		// owner took it
	input  spi_rsp_t						done_data,		// received byte

	output logic [`SPI_NUM_CLIENTS-1:0]		rsp_valid,		// per client response
	input  logic [`SPI_NUM_CLIENTS-1:0]		rsp_ready,		// per client accept
	output spi_rsp_t						rsp_data		// shared response bus
);

	client_id_t		last_win;	// previous grant
	client_id_t		owner;		// client of the running transfer
	client_id_t		grant;		// candidate this cycle

	// tie goes to whoever did not win last
	always_comb begin
		if (req_valid[0] && req_valid[1])
			grant	= ~last_win;
		else if (req_valid[1])
			grant	= 1'b1;
		else
			grant	= 1'b0;
	end

	assign start_valid	= start_ready && (|req_valid);	// grant only when engine free
	assign start_req	= (grant == 1'b1) ? req_data1 : req_data0;
	assign done_ready	= rsp_ready[owner];				// only owner can release engine
	assign rsp_data		= done_data;					// qualified by rsp_valid

	always_comb begin
		for (int i = 0; i < `SPI_NUM_CLIENTS; i++) begin
			req_pop[i]		= start_valid && (grant == client_id_t'(i));
			rsp_valid[i]	= done_valid && (owner == client_id_t'(i));
		end
	end

	// client 0 wins the first tie
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			last_win	<= 1'b1;
			owner		<= 1'b0;
		end else if (start_valid) begin
			last_win	<= grant;
			owner		<= grant;	// held until next grant
		end
	end

endmodule

`default_nettype wire

// ==== spi_master_core.sv ====
// spi master engine, one 8-bit full-duplex transfer per start
// sclk generation with cpol/cpha, divider, chip-select decode
// response is held until done_ready
`timescale 1ns/100ps
`include "spi_sub_defines.svh"
`default_nettype none

module spi_master_core
	import spi_bus_pkg::*;
	import spi_client_pkg::*;
#(
	parameter logic CPOL = 1'b1,		// sclk idle level
	parameter logic CPHA = 1'b1			// 1 = sample on trailing edge
) (
	input  logic						sys_clk,		// system clock
	input  logic						sys_rst_n,		// sync reset, low active
	input  logic [`SPI_DIV_W-1:0]		clk_div_val,	// half period minus one

	input  logic						start_valid,	// new transfer
	output logic						start_ready,	// engine idle
	input  spi_req_t					start_req,		// byte and slave

	output logic						done_valid,		// byte received
	input  logic						done_ready,		// consumer accepts
	output spi_rsp_t					done_data,		// received byte

	output logic						sclk,			// serial clock
	output logic [`SPI_NUM_CS-1:0]		cs_n,			// one per slave, low active
	output logic						mosi,			// master out
	input  logic						miso			// master in
);

	spi_state_t					state;			// current state
	spi_state_t					state_nxt;		// next state
	logic [`SPI_DIV_W-1:0]		cnt_clk;		// cycles inside a half period
	logic [`SPI_DIV_W:0]		cnt_inc;		// cnt_clk + 1, no wrap
	logic [4:0]					cnt_edge;		// sclk edge index 0..15
	spi_data_t					mosi_shift;		// outgoing bits
	spi_data_t					miso_shift;		// incoming bits
	logic						div_zero;		// edge every cycle
	logic						wait_done;		// leave sclk wait
	logic						half_done;		// leave last half
	logic						last_edge;		// 16th edge
	logic						shift_en;		// advance mosi
	logic						sample_en;		// capture miso

	assign cnt_inc		= {1'b0, cnt_clk} + 1'b1;
	assign div_zero		= (clk_div_val == '0);
	assign wait_done	= (cnt_inc >= {1'b0, clk_div_val});	// wait plus edge = div+1
	assign half_done	= (cnt_clk >= clk_div_val);
	assign last_edge	= (cnt_edge == 5'd15);

	// even edges are leading, odd edges trailing
	assign shift_en		= (state == ST_SCLK_EDGE) &&
						  (CPHA ? (cnt_edge != 5'd0 && !cnt_edge[0]) : cnt_edge[0]);
	assign sample_en	= (state == ST_SCLK_EDGE) &&
						  (CPHA ? cnt_edge[0] : !cnt_edge[0]);

	assign start_ready	= (state == ST_IDLE);
	assign done_valid	= (state == ST_RSP_HOLD);
	assign done_data	= miso_shift;				// frozen while holding
	assign mosi			= mosi_shift[`SPI_DATA_W-1];	// msb first

	always_comb begin
		state_nxt	= state;
		case (state)
			ST_IDLE:
				if (start_valid)
					state_nxt	= div_zero ? ST_SCLK_EDGE : ST_SCLK_WAIT;
			ST_SCLK_WAIT:
				if (wait_done)
					state_nxt	= ST_SCLK_EDGE;
			ST_SCLK_EDGE:
				if (last_edge)
					state_nxt	= ST_LAST_HALF;
				else if (div_zero)
					state_nxt	= ST_SCLK_EDGE;	// back-to-back edges
				else
					state_nxt	= ST_SCLK_WAIT;
			ST_LAST_HALF:
				if (half_done)
					state_nxt	= ST_RSP_HOLD;
			ST_RSP_HOLD:
				if (done_ready)
					state_nxt	= ST_IDLE;		// owner released the byte
			default:
				state_nxt	= ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			state	<= ST_IDLE;
		else
			state	<= state_nxt;
	end

	// divider counter, restarts each half period
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk	<= '0;
		else if ((state == ST_SCLK_WAIT && !wait_done) ||
				 (state == ST_LAST_HALF && !half_done))
			cnt_clk	<= cnt_clk + 1'b1;
		else
			cnt_clk	<= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_edge	<= 5'd0;
		else if (state == ST_IDLE)
			cnt_edge	<= 5'd0;
		else if (state == ST_SCLK_EDGE)
			cnt_edge	<= cnt_edge + 5'd1;
	end

	// 16 toggles bring sclk back to cpol
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			sclk	<= CPOL;
		else if (state == ST_IDLE)
			sclk	<= CPOL;
		else if (state == ST_SCLK_EDGE)
			sclk	<= ~sclk;
	end

	// select goes low the cycle after start, high again with done_valid
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cs_n	<= '1;
		else if (state == ST_IDLE && start_valid)
			cs_n	<= ~(`SPI_NUM_CS'(1) << start_req.cs);
		else if (state == ST_LAST_HALF && half_done)
			cs_n	<= '1;
	end

	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE && start_valid)
			mosi_shift	<= start_req.data;		// first bit out before any edge
		else if (shift_en)
			mosi_shift	<= {mosi_shift[`SPI_DATA_W-2:0], 1'b0};
	end

	always_ff @(posedge sys_clk) begin
		if (sample_en)
			miso_shift	<= {miso_shift[`SPI_DATA_W-2:0], miso};
	end

endmodule

`default_nettype wire

// ==== spi_sub_top.sv ====
// shared spi master subsystem top level
// two request buffers, round-robin arbiter, one spi engine
`timescale 1ns/100ps
`include "spi_sub_defines.svh"
`default_nettype none

module spi_sub_top
	import spi_bus_pkg::*;
	import spi_client_pkg::*;
#(
	parameter logic CPOL = 1'b1,	// sclk idle level
	parameter logic CPHA = 1'b1		// sampling edge select
) (
	input  logic						sys_clk,		// system clock
	input  logic						sys_rst_n,		// sync reset, low active

	// client 0
	input  logic						c0_req_valid,	// request offered
	output logic						c0_req_ready,	// buffer can take it
	input  spi_data_t					c0_req_data,	// byte to send
	input  spi_cs_idx_t					c0_req_cs,		// target slave
	output logic						c0_rsp_valid,	// response present
	input  logic						c0_rsp_ready,	// client accepts
	output spi_data_t					c0_rsp_data,	// received byte

	// client 1
	input  logic						c1_req_valid,
	output logic						c1_req_ready,
	input  spi_data_t					c1_req_data,
	input  spi_cs_idx_t					c1_req_cs,
	output logic						c1_rsp_valid,
	input  logic						c1_rsp_ready,
	output spi_data_t					c1_rsp_data,

	// shared serial side
	input  logic [`SPI_DIV_W-1:0]		clk_div_val,	// half period minus one
	output logic						sclk,			// serial clock
	output logic [`SPI_NUM_CS-1:0]		cs_n,			// slave selects
	output logic						mosi,			// master out
	input  logic						miso			// master in
);

	spi_req_t							c0_req_pl;		// packed client 0 request
	spi_req_t							c1_req_pl;		// packed client 1 request
	spi_req_t							buf0_data;		// buffered client 0 item
	spi_req_t							buf1_data;		// buffered client 1 item
	logic [`SPI_NUM_CLIENTS-1:0]		buf_valid;		// buffers holding items
	logic [`SPI_NUM_CLIENTS-1:0]		buf_pop;		// arbiter drains a buffer
	logic [`SPI_NUM_CLIENTS-1:0]		rsp_valid;		// routed response valid
	logic [`SPI_NUM_CLIENTS-1:0]		rsp_ready;		// gathered response ready
	spi_rsp_t							rsp_data;		// shared response byte
	logic								start_valid;	// arbiter to core
	logic								start_ready;
	spi_req_t							start_req;
	logic								done_valid;		// core to arbiter
	logic								done_ready;
	spi_rsp_t							done_data;

	assign c0_req_pl	= '{data: c0_req_data, cs: c0_req_cs};
	assign c1_req_pl	= '{data: c1_req_data, cs: c1_req_cs};
	assign rsp_ready	= {c1_rsp_ready, c0_rsp_ready};
	assign c0_rsp_valid	= rsp_valid[0];
	assign c1_rsp_valid	= rsp_valid[1];
	assign c0_rsp_data	= rsp_data;			// both see the bus, valid decides
	assign c1_rsp_data	= rsp_data;

	spi_req_buffer #(.payload_t(spi_req_t)) u_buf0 (
		.sys_clk	(sys_clk),
		.sys_rst_n	(sys_rst_n),
		.in_valid	(c0_req_valid),
		.in_ready	(c0_req_ready),
		.in_data	(c0_req_pl),
		.out_valid	(buf_valid[0]),
		.out_ready	(buf_pop[0]),
		.out_data	(buf0_data)
	);

	spi_req_buffer #(.payload_t(spi_req_t)) u_buf1 (
		.sys_clk	(sys_clk),
		.sys_rst_n	(sys_rst_n),
		.in_valid	(c1_req_valid),
		.in_ready	(c1_req_ready),
		.in_data	(c1_req_pl),
		.out_valid	(buf_valid[1]),
		.out_ready	(buf_pop[1]),
		.out_data	(buf1_data)
	);

	spi_rr_arbiter u_arb (
		.sys_clk		(sys_clk),
		.sys_rst_n		(sys_rst_n),
		.req_valid		(buf_valid),
		.req_pop		(buf_pop),
		.req_data0		(buf0_data),
		.req_data1		(buf1_data),
		.start_valid	(start_valid),
		.start_ready	(start_ready),
		.start_req		(start_req),
		.done_valid		(done_valid),
		.done_ready		(done_ready),
		.done_data		(done_data),
		.rsp_valid		(rsp_valid),
		.rsp_ready		(rsp_ready),
		.rsp_data		(rsp_data)
	);

	spi_master_core #(.CPOL(CPOL), .CPHA(CPHA)) u_core (
		.sys_clk		(sys_clk),
		.sys_rst_n		(sys_rst_n),
		.clk_div_val	(clk_div_val),
		.start_valid	(start_valid),
		.start_ready	(start_ready),
		.start_req		(start_req),
		.done_valid		(done_valid),
		.done_ready		(done_ready),
		.done_data		(done_data),
		.sclk			(sclk),
		.cs_n			(cs_n),
		.mosi			(mosi),
		.miso			(miso)
	);

endmodule

`default_nettype wire

// ==== spi_sub_properties.sv ====
// bound assertions for the spi subsystem top level
// select exclusivity, sclk idle level, response hold under back-pressure
`timescale 1ns/100ps
`include "spi_sub_defines.svh"
`default_nettype none

module spi_sub_properties
	import spi_bus_pkg::*;
#(
	parameter logic CPOL = 1'b1		// sclk idle level
) (
	input logic						sys_clk,
	input logic						sys_rst_n,
	input logic [`SPI_NUM_CS-1:0]	cs_n,
	input logic						sclk,
	input spi_state_t				core_state,		// engine FSM
	input logic						c0_rsp_valid,
	input logic						c0_rsp_ready,
	input spi_data_t				c0_rsp_data,
	input logic						c1_rsp_valid,
	input logic						c1_rsp_ready,
	input spi_data_t				c1_rsp_data
);

	int assert_fails = 0;		// read by the testbench at the end

	a_one_select: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$countones(~cs_n) <= 1)
		else begin assert_fails++; $error("two slave selects low together"); end

	// no slave selected means sclk rests
	a_sclk_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(&cs_n) |-> (sclk == CPOL))
		else begin assert_fails++; $error("sclk off its idle level"); end

	a_hold_deselect: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(core_state == ST_RSP_HOLD) |-> (&cs_n))
		else begin assert_fails++; $error("select low while holding response"); end

	a_c0_rsp_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(c0_rsp_valid && !c0_rsp_ready) |=> (c0_rsp_valid && $stable(c0_rsp_data)))
		else begin assert_fails++; $error("client 0 response dropped or changed"); end

	a_c1_rsp_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(c1_rsp_valid && !c1_rsp_ready) |=> (c1_rsp_valid && $stable(c1_rsp_data)))
		else begin assert_fails++; $error("client 1 response dropped or changed"); end

endmodule

bind spi_sub_top spi_sub_properties #(.CPOL(CPOL)) u_props (
	.sys_clk		(sys_clk),
	.sys_rst_n		(sys_rst_n),
	.cs_n			(cs_n),
	.sclk			(sclk),
	.core_state		(u_core.state),
	.c0_rsp_valid	(c0_rsp_valid),
	.c0_rsp_ready	(c0_rsp_ready),
	.c0_rsp_data	(c0_rsp_data),
	.c1_rsp_valid	(c1_rsp_valid),
	.c1_rsp_ready	(c1_rsp_ready),
	.c1_rsp_data	(c1_rsp_data)
);

`default_nettype wire

// ==== tb_spi_sub.sv ====
// testbench for the shared spi master subsystem
// clock, reset, behavioral spi slave per select line, directed tests, timeout
`timescale 1ns/100ps
`include "spi_sub_defines.svh"
`default_nettype none

module tb_spi_sub;

	localparam logic	TB_CPOL		= 1'b1;
	localparam logic	TB_CPHA		= 1'b1;
	localparam int		MAX_XFERS	= 24;				// transfers over all tests
	localparam int		WORST_XFER	= 17 * 11 + 8;		// div 10 plus handshake slack
	localparam int		CYCLE_LIMIT	= MAX_XFERS * WORST_XFER + 200;	// about 5000

	logic						sys_clk;
	logic						sys_rst_n;
	logic						c0_req_valid;
	logic						c0_req_ready;
	logic [`SPI_DATA_W-1:0]		c0_req_data;
	logic						c0_req_cs;
	logic						c0_rsp_valid;
	logic						c0_rsp_ready;
	logic [`SPI_DATA_W-1:0]		c0_rsp_data;
	logic						c1_req_valid;
	logic						c1_req_ready;
	logic [`SPI_DATA_W-1:0]		c1_req_data;
	logic						c1_req_cs;
	logic						c1_rsp_valid;
	logic						c1_rsp_ready;
	logic [`SPI_DATA_W-1:0]		c1_rsp_data;
	logic [`SPI_DIV_W-1:0]		clk_div_val;
	logic						sclk;
	logic [`SPI_NUM_CS-1:0]		cs_n;
	logic						mosi;
	logic						miso;

	int							seed = 90;					// $random seed
	int							cycle_cnt;
	string						test_name = "init";
	logic [7:0]					exp_hist [`SPI_NUM_CS];		// last byte sent per slave
	logic [7:0]					slv_last [`SPI_NUM_CS];		// slave side history
	logic [7:0]					slv_tx;						// byte the slave returns
	logic [7:0]					slv_rx;						// byte the slave collects
	int							slv_sel = -1;				// active select, -1 idle
	int							slv_bits;					// rising sclk while selected
	int							slv_falls;
	int							sel_log [$];				// order of selects

	spi_sub_top #(.CPOL(TB_CPOL), .CPHA(TB_CPHA)) DUT (.*);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;		// 100 ns period
	end

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("error: test %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// slave model returns the previous byte xor a5 msb first
	task automatic open_slave(input int idx);
		check_value("other select idle", 1'b1, cs_n[1 - idx]);
		sel_log.push_back(idx);
		slv_sel		= idx;
		slv_tx		= slv_last[idx] ^ 8'hA5;
		slv_bits	= 0;
		slv_falls	= 0;
		#1 miso		= slv_tx[7];		// first bit before any edge
	endtask

	task automatic close_slave(input int idx);
		if (slv_sel == idx) begin		// ignores the x to 1 at power up
			slv_last[idx]	= slv_rx;
			slv_sel			= -1;
		end
	endtask

	always @(negedge cs_n[0]) open_slave(0);
	always @(negedge cs_n[1]) open_slave(1);
	always @(posedge cs_n[0]) close_slave(0);
	always @(posedge cs_n[1]) close_slave(1);

	always @(posedge sclk) begin
		if (slv_sel >= 0) begin
			slv_rx = {slv_rx[6:0], mosi};
			slv_bits++;
		end
	end

	always @(negedge sclk) begin
		if (slv_sel >= 0 && slv_falls < 8) begin
			#1 miso = slv_tx[7 - slv_falls];	// first fall repeats bit 7
			slv_falls++;
		end
	end

	task automatic set_req(input int c, input logic v, input logic [7:0] d, input logic cs);
		if (c == 0) begin
			c0_req_valid	= v;
			c0_req_data		= d;
			c0_req_cs		= cs;
		end else begin
			c1_req_valid	= v;
			c1_req_data		= d;
			c1_req_cs		= cs;
		end
	endtask

	// valid stays up until the buffer takes it
	task automatic send_req(input int c, input logic [7:0] d, input logic cs);
		logic ok;
		set_req(c, 1'b1, d, cs);
		do begin
			@(negedge sys_clk);
			ok = (c == 0) ? c0_req_ready : c1_req_ready;
			@(posedge sys_clk);
			#1;
		end while (!ok);
		set_req(c, 1'b0, d, cs);
	endtask

	task automatic await_rsp(input int c);
		do begin
			@(negedge sys_clk);
		end while (!((c == 0) ? c0_rsp_valid : c1_rsp_valid));
	endtask

	// rsp_ready is high when this runs, so the handshake ends at the next edge
	task automatic collect_rsp(input int c, input int cs, input logic [7:0] sent);
		logic [7:0] got;
		await_rsp(c);
		got = (c == 0) ? c0_rsp_data : c1_rsp_data;
		check_value("response byte", exp_hist[cs] ^ 8'hA5, got);
		check_value("byte at slave", sent, slv_last[cs]);
		check_value("bits at slave", 8, slv_bits);
		exp_hist[cs] = sent;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic reset_state_check();
		test_name = "reset";
		@(negedge sys_clk);
		check_value("sclk idle", TB_CPOL, sclk);
		check_value("selects idle", 2'b11, cs_n);
		check_value("req ready", 2'b11, {c1_req_ready, c0_req_ready});
		check_value("rsp valid", 2'b00, {c1_rsp_valid, c0_rsp_valid});
		@(posedge sys_clk);
		#1;
	endtask

	task automatic single_transfer();
		logic [7:0] d;
		test_name	= "single";
		d			= $random(seed);
		send_req(0, d, 1'b0);
		collect_rsp(0, 0, d);
	endtask

	task automatic cs_routing();
		logic [7:0]	d;
		logic		cs;
		test_name = "cs routing";
		for (int i = 0; i < 4; i++) begin
			d	= $random(seed);
			cs	= i % 2;					// alternate slaves
			if (i == 2)
				c1_rsp_ready = 1'b0;		// client 1 stalls this response
			send_req(1, d, cs);
			if (i == 2) begin
				await_rsp(1);
				repeat (5) @(posedge sys_clk);
				#1 c1_rsp_ready = 1'b1;
			end
			collect_rsp(1, cs, d);
			check_value("addressed select", cs, sel_log[$]);
		end
	endtask

	// client n talks to slave n, so the select order is the grant order
	task automatic round_robin();
		logic [7:0]	d0;
		logic [7:0]	d1;
		int			base;
		int			prev;
		int			exp_order [$];
		test_name	= "round robin";
		base		= sel_log.size();
		prev		= 1;							// cs routing ran on client 1
		for (int r = 0; r < 3; r++) begin
			if (r == 1) begin						// client 0 wins alone before this tie
				d0 = $random(seed);
				send_req(0, d0, 1'b0);
				collect_rsp(0, 0, d0);
				exp_order.push_back(0);
				prev = 0;
			end
			d0 = $random(seed);
			d1 = $random(seed);
			fork
				send_req(0, d0, 1'b0);
				send_req(1, d1, 1'b1);
			join
			fork
				collect_rsp(0, 0, d0);
				collect_rsp(1, 1, d1);
			join
			exp_order.push_back(1 - prev);			// tie goes to the client that lost last
			exp_order.push_back(prev);				// which leaves prev as last winner
		end
		foreach (exp_order[k])
			check_value("grant order", exp_order[k], sel_log[base + k]);
	endtask

	task automatic backpressure();
		logic [7:0]	a;
		logic [7:0]	b;
		logic [7:0]	c;
		logic [7:0]	held;
		int			n_sel;
		test_name		= "back-pressure";
		a				= $random(seed);
		b				= $random(seed);
		c				= $random(seed);
		c0_rsp_ready	= 1'b0;
		send_req(0, a, 1'b0);
		send_req(0, b, 1'b0);				// parks in the buffer
		await_rsp(0);
		held	= c0_rsp_data;
		n_sel	= sel_log.size();
		@(posedge sys_clk);
		#1;
		set_req(0, 1'b1, c, 1'b0);			// stalls while the buffer is full
		repeat (40) begin
			@(negedge sys_clk);
			check_value("rsp valid held", 1'b1, c0_rsp_valid);
			check_value("rsp data held", held, c0_rsp_data);
			check_value("req ready low", 1'b0, c0_req_ready);
		end
		check_value("no new select", n_sel, sel_log.size());
		@(posedge sys_clk);
		#1;
		c0_rsp_ready = 1'b1;
		collect_rsp(0, 0, a);
		send_req(0, c, 1'b0);
		collect_rsp(0, 0, b);
		collect_rsp(0, 0, c);
	endtask

	task automatic divider_sweep();
		int			divs [3] = '{0, 3, 10};
		logic [7:0]	d;
		logic		cs;
		int			c;
		test_name = "divider";
		foreach (divs[j]) begin
			clk_div_val = divs[j];			// engine idle here
			for (int k = 0; k < 3; k++) begin
				d	= $random(seed);
				cs	= $random(seed);
				c	= k % 2;
				send_req(c, d, cs);
				collect_rsp(c, cs, d);
				@(negedge sys_clk);
				check_value("sclk at rest", TB_CPOL, sclk);
				check_value("selects idle", 2'b11, cs_n);
				@(posedge sys_clk);
				#1;
			end
		end
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		sys_rst_n		= 1'b0;
		c0_rsp_ready	= 1'b1;
		c1_rsp_ready	= 1'b1;
		clk_div_val		= `SPI_DIV_DEFAULT;
		miso			= 1'b0;
		set_req(0, 1'b0, 8'h00, 1'b0);
		set_req(1, 1'b0, 8'h00, 1'b0);
		foreach (exp_hist[i]) begin
			exp_hist[i] = 8'h00;			// both slaves start from 00
			slv_last[i] = 8'h00;
		end
		repeat (3) @(posedge sys_clk);
		#1 sys_rst_n = 1'b1;
		reset_state_check();
		single_transfer();
		cs_routing();
		round_robin();
		backpressure();
		divider_sweep();
		if (DUT.u_props.assert_fails == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("%0d assertion failures in the bound checker", DUT.u_props.assert_fails);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
spi_bus_pkg.sv
spi_client_pkg.sv
spi_req_buffer.sv
spi_rr_arbiter.sv
spi_master_core.sv
spi_sub_top.sv
spi_sub_properties.sv
tb_spi_sub.sv
